// File: logic/lsq_pkg.sv
`default_nettype none

package lsq_pkg;

	// *******************************************************************
	// widths
	// *******************************************************************
	localparam int ADDR_W = 11;
	localparam int DATA_W = 64;
	// byte offset inside a word, not used for matching
	localparam int OFS_W = 3;
	localparam int ROB_IDX_W = 5;
	localparam int PRF_IDX_W = 6;
	localparam int BR_MASK_W = 4;

	// queue depths, pointers carry one extra wrap bit
	localparam int SQ_ENT_NUM = 8;
	localparam int SQ_IDX_W = 3;
	localparam int LQ_ENT_NUM = 4;
	localparam int LQ_IDX_W = 2;

	// *******************************************************************
	// cache geometry
	// *******************************************************************
	localparam int MEM_WORDS = 256;
	localparam int MEM_IDX_W = $clog2(MEM_WORDS);
	localparam int LINE_NUM = 16;
	localparam int LINE_IDX_W = $clog2(LINE_NUM);
	localparam int TAG_W = ADDR_W - OFS_W - LINE_IDX_W;
	// ack cycle to refill response
	localparam int MISS_LATENCY = 4;
	localparam int MISS_CNT_W = $clog2(MISS_LATENCY);

	typedef enum logic {
		HOLD_IDLE,
		HOLD_BUSY
	} hold_state_e;

	typedef enum logic [1:0] {
		MSHR_IDLE,
		MSHR_WAIT,
		MSHR_RESP
	} mshr_state_e;

	function automatic logic same_word(input logic [ADDR_W-1:0] a, input logic [ADDR_W-1:0] b);
		return a[ADDR_W-1:OFS_W] == b[ADDR_W-1:OFS_W];
	endfunction

endpackage

`default_nettype wire

// File: logic/store_queue.sv
`timescale 1ns/1ps
`default_nettype none

module store_queue import lsq_pkg::*; (
	input  wire                               clk,
	input  wire                               rst,
	input  wire                               dp_en_i,
	input  wire                               st_vld_i,
	input  wire [SQ_IDX_W-1:0]                sq_idx_i,
	input  wire [ADDR_W-1:0]                  addr_i,
	input  wire [DATA_W-1:0]                  st_data_i,
	input  wire                               st_retire_i,
	input  wire                               br_recovery_i,
	input  wire [SQ_IDX_W:0]                  sq_tail_recovery_i,
	input  wire                               st_ack_i,
	output logic [SQ_IDX_W:0]                 sq_tail_o,
	output logic [SQ_IDX_W-1:0]               sq_head_o,
	output logic                              sq_full_o,
	output logic [SQ_ENT_NUM-1:0][ADDR_W-1:0] st_addr_arr_o,
	output logic [SQ_ENT_NUM-1:0][DATA_W-1:0] st_data_arr_o,
	output logic [SQ_ENT_NUM-1:0]             st_addr_vld_o,
	output logic                              st_en_o,
	output logic [ADDR_W-1:0]                 st_addr_o,
	output logic [DATA_W-1:0]                 st_data_o
);

	logic [SQ_IDX_W:0]     head_q;
	logic [SQ_IDX_W:0]     tail_q;
	logic [SQ_IDX_W-1:0]   head;
	logic [SQ_IDX_W-1:0]   tail;
	// retired but not yet written to the cache
	logic [SQ_IDX_W:0]     ret_cnt;
	logic [SQ_IDX_W:0]     occ;
	logic                  drain;
	logic [SQ_ENT_NUM-1:0] addr_vld_nxt;

	assign head = head_q[SQ_IDX_W-1:0];
	assign tail = tail_q[SQ_IDX_W-1:0];
	assign occ = tail_q - head_q;

	assign sq_tail_o = tail_q;
	assign sq_head_o = head;
	assign sq_full_o = (head == tail) && (head_q[SQ_IDX_W] != tail_q[SQ_IDX_W]);

	// *******************************************************************
	// drain to cache
	// *******************************************************************
	assign st_en_o = (ret_cnt != '0) && st_addr_vld_o[head];
	assign st_addr_o = st_addr_arr_o[head];
	assign st_data_o = st_data_arr_o[head];
	assign drain = st_en_o && st_ack_i;

	always_comb begin
		addr_vld_nxt = st_addr_vld_o;
		if (dp_en_i)
			addr_vld_nxt[tail] = 1'b0;
		if (st_vld_i)
			addr_vld_nxt[sq_idx_i] = 1'b1;
		if (drain)
			addr_vld_nxt[head] = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (st_vld_i) begin
			st_addr_arr_o[sq_idx_i] <= addr_i;
			st_data_arr_o[sq_idx_i] <= st_data_i;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head_q <= '0;
			tail_q <= '0;
			ret_cnt <= '0;
			st_addr_vld_o <= '0;
		end else begin
			if (drain)
				head_q <= head_q + 1'b1;
			// recovery wins over a dispatch in the same cycle
			if (br_recovery_i)
				tail_q <= sq_tail_recovery_i;
			else if (dp_en_i)
				tail_q <= tail_q + 1'b1;
			ret_cnt <= ret_cnt + (SQ_IDX_W+1)'(st_retire_i) - (SQ_IDX_W+1)'(drain);
			st_addr_vld_o <= addr_vld_nxt;
		end
	end

	// *******************************************************************
	// checks
	// *******************************************************************
	a_retire_alloc: assert property (@(posedge clk) disable iff (rst)
		st_retire_i |-> (ret_cnt < occ));

	a_dp_not_full: assert property (@(posedge clk) disable iff (rst)
		dp_en_i |-> !sq_full_o);

endmodule

`default_nettype wire

// File: logic/store_forward.sv
`timescale 1ns/1ps
`default_nettype none

module store_forward import lsq_pkg::*; (
	input  wire                              ld_vld_i,
	input  wire [ADDR_W-1:0]                 addr_i,
	input  wire [SQ_IDX_W-1:0]               rs_ld_position_i,
	input  wire [SQ_IDX_W-1:0]               ex_ld_position_i,
	input  wire [SQ_IDX_W-1:0]               sq_head_i,
	input  wire                              sq_full_i,
	input  wire [SQ_ENT_NUM-1:0][ADDR_W-1:0] st_addr_arr_i,
	input  wire [SQ_ENT_NUM-1:0][DATA_W-1:0] st_data_arr_i,
	input  wire [SQ_ENT_NUM-1:0]             st_addr_vld_i,
	output logic                             older_st_known_o,
	output logic                             fwd_vld_o,
	output logic [DATA_W-1:0]                fwd_data_o
);

	// number of stores between head and the load
	logic [SQ_IDX_W-1:0] rs_len;
	logic [SQ_IDX_W-1:0] ex_len;
	logic [SQ_IDX_W-1:0] idx;

	// a zero length window with a full queue covers every entry
	function automatic logic in_window(input int ofs, input logic [SQ_IDX_W-1:0] len,
		input logic full);
		return (ofs < int'(len)) || ((len == '0) && full);
	endfunction

	assign rs_len = rs_ld_position_i - sq_head_i;
	assign ex_len = ex_ld_position_i - sq_head_i;

	// walk from oldest to youngest, so the last match is the youngest
	always_comb begin
		older_st_known_o = 1'b1;
		fwd_vld_o = 1'b0;
		fwd_data_o = '0;
		idx = sq_head_i;
		for (int k = 0; k < SQ_ENT_NUM; k++) begin
			idx = sq_head_i + SQ_IDX_W'(k);
			if (in_window(k, rs_len, sq_full_i) && !st_addr_vld_i[idx])
				older_st_known_o = 1'b0;
			if (ld_vld_i && in_window(k, ex_len, sq_full_i) && st_addr_vld_i[idx] &&
				same_word(st_addr_arr_i[idx], addr_i)) begin
				fwd_vld_o = 1'b1;
				fwd_data_o = st_data_arr_i[idx];
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/load_miss_queue.sv
`timescale 1ns/1ps
`default_nettype none

module load_miss_queue import lsq_pkg::*; (
	input  wire                  clk,
	input  wire                  rst,
	input  wire                  ld_vld_i,
	input  wire [ADDR_W-1:0]     addr_i,
	input  wire [ROB_IDX_W:0]    rob_idx_i,
	input  wire [PRF_IDX_W-1:0]  dest_tag_i,
	input  wire [BR_MASK_W-1:0]  br_mask_i,
	input  wire                  fwd_vld_i,
	input  wire [DATA_W-1:0]     fwd_data_i,
	input  wire                  older_st_known_i,
	input  wire                  hit_i,
	input  wire [DATA_W-1:0]     hit_data_i,
	input  wire                  ld_ack_i,
	input  wire                  mshr_stall_i,
	input  wire                  mshr_vld_i,
	input  wire [ADDR_W-1:0]     mshr_addr_i,
	input  wire [DATA_W-1:0]     mshr_data_i,
	input  wire                  br_recovery_i,
	input  wire                  br_pred_correct_i,
	input  wire [BR_MASK_W-1:0]  br_tag_fix_i,
	input  wire                  cdb_busy_i,
	output logic                 ld_iss_en_o,
	output logic                 ld_en_o,
	output logic [ADDR_W-1:0]    ld_addr_o,
	output logic                 ld_done_o,
	output logic [DATA_W-1:0]    ld_data_o,
	output logic [ROB_IDX_W:0]   ld_rob_idx_o,
	output logic [PRF_IDX_W-1:0] ld_dest_tag_o,
	output logic                 lq_com_rdy_o,
	output logic [DATA_W-1:0]    lq_data_o,
	output logic [ROB_IDX_W:0]   lq_rob_idx_o,
	output logic [PRF_IDX_W-1:0] lq_dest_tag_o,
	output logic [BR_MASK_W-1:0] lq_br_mask_o
);

	hold_state_e          hold_state;
	hold_state_e          hold_state_nxt;
	logic [ADDR_W-1:0]    hold_addr;
	logic [ROB_IDX_W:0]   hold_rob_idx;
	logic [PRF_IDX_W-1:0] hold_dest_tag;
	logic [BR_MASK_W-1:0] hold_br_mask;

	logic                 req_vld;
	logic                 req_fwd;
	logic [ADDR_W-1:0]    req_addr;
	logic [ROB_IDX_W:0]   req_rob_idx;
	logic [PRF_IDX_W-1:0] req_dest_tag;
	logic [BR_MASK_W-1:0] req_br_mask;
	logic [BR_MASK_W-1:0] req_mask_upd;
	logic                 req_kill;

	logic [LQ_IDX_W:0]    head_q;
	logic [LQ_IDX_W:0]    tail_q;
	logic [LQ_IDX_W-1:0]  head;
	logic [LQ_IDX_W-1:0]  tail;
	logic                 lq_empty;
	logic                 lq_full;
	logic                 head_fill;
	logic                 head_rdy;
	logic                 head_adv;

	logic [LQ_ENT_NUM-1:0][ADDR_W-1:0]    lq_addr;
	logic [LQ_ENT_NUM-1:0][DATA_W-1:0]    lq_data;
	logic [LQ_ENT_NUM-1:0][ROB_IDX_W:0]   lq_rob_idx;
	logic [LQ_ENT_NUM-1:0][PRF_IDX_W-1:0] lq_dest_tag;
	logic [LQ_ENT_NUM-1:0][BR_MASK_W-1:0] lq_br_mask;
	logic [LQ_ENT_NUM-1:0]                lq_vld;
	logic [LQ_ENT_NUM-1:0]                lq_rdy;

	// *******************************************************************
	// execute side, new load or the held one
	// *******************************************************************
	assign req_vld = ld_vld_i || (hold_state == HOLD_BUSY);
	assign req_fwd = ld_vld_i && fwd_vld_i;
	assign req_addr = ld_vld_i ? addr_i : hold_addr;
	assign req_rob_idx = ld_vld_i ? rob_idx_i : hold_rob_idx;
	assign req_dest_tag = ld_vld_i ? dest_tag_i : hold_dest_tag;
	assign req_br_mask = ld_vld_i ? br_mask_i : hold_br_mask;
	assign req_mask_upd = br_pred_correct_i ? (req_br_mask & ~br_tag_fix_i) : req_br_mask;
	assign req_kill = br_recovery_i && ((req_br_mask & br_tag_fix_i) != '0);

	assign ld_en_o = req_vld && !req_fwd && !mshr_vld_i && !lq_full;
	assign ld_addr_o = req_addr;
	assign ld_done_o = (req_fwd || (req_vld && hit_i)) && !mshr_vld_i;
	assign ld_data_o = req_fwd ? fwd_data_i : hit_data_i;
	assign ld_rob_idx_o = req_rob_idx;
	assign ld_dest_tag_o = req_dest_tag;

	assign ld_iss_en_o = older_st_known_i && !lq_full && !mshr_stall_i &&
		(hold_state_nxt == HOLD_IDLE);

	always_comb begin
		hold_state_nxt = hold_state;
		if (ld_vld_i && !ld_done_o && !ld_ack_i && !req_kill)
			hold_state_nxt = HOLD_BUSY;
		else if (ld_ack_i || ld_done_o || req_kill)
			hold_state_nxt = HOLD_IDLE;
	end

	always_ff @(posedge clk) begin
		if (rst)
			hold_state <= HOLD_IDLE;
		else
			hold_state <= hold_state_nxt;
	end

	always_ff @(posedge clk) begin
		if (ld_vld_i) begin
			hold_addr <= addr_i;
			hold_rob_idx <= rob_idx_i;
			hold_dest_tag <= dest_tag_i;
		end
		if (req_vld)
			hold_br_mask <= req_mask_upd;
	end

	// *******************************************************************
	// miss buffer
	// *******************************************************************
	assign head = head_q[LQ_IDX_W-1:0];
	assign tail = tail_q[LQ_IDX_W-1:0];
	assign lq_empty = head_q == tail_q;
	assign lq_full = (head == tail) && (head_q[LQ_IDX_W] != tail_q[LQ_IDX_W]);

	assign head_fill = mshr_vld_i && same_word(mshr_addr_i, lq_addr[head]);
	assign head_rdy = !lq_empty && (lq_rdy[head] || head_fill);
	assign lq_com_rdy_o = head_rdy && lq_vld[head];
	assign lq_data_o = lq_rdy[head] ? lq_data[head] : mshr_data_i;
	assign lq_rob_idx_o = lq_rob_idx[head];
	assign lq_dest_tag_o = lq_dest_tag[head];
	assign lq_br_mask_o = lq_br_mask[head];
	// squashed heads leave without a completion
	assign head_adv = !lq_empty && (!lq_vld[head] || (head_rdy && !cdb_busy_i));

	always_ff @(posedge clk) begin
		if (rst) begin
			head_q <= '0;
			tail_q <= '0;
			lq_vld <= '0;
			lq_rdy <= '0;
		end else begin
			if (head_adv)
				head_q <= head_q + 1'b1;
			if (ld_ack_i)
				tail_q <= tail_q + 1'b1;
			for (int k = 0; k < LQ_ENT_NUM; k++) begin
				if (br_recovery_i && ((lq_br_mask[k] & br_tag_fix_i) != '0))
					lq_vld[k] <= 1'b0;
				if (mshr_vld_i && same_word(mshr_addr_i, lq_addr[k]))
					lq_rdy[k] <= 1'b1;
			end
			if (ld_ack_i) begin
				lq_vld[tail] <= !req_kill;
				lq_rdy[tail] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int k = 0; k < LQ_ENT_NUM; k++) begin
			if (br_pred_correct_i)
				lq_br_mask[k] <= lq_br_mask[k] & ~br_tag_fix_i;
			if (mshr_vld_i && same_word(mshr_addr_i, lq_addr[k]))
				lq_data[k] <= mshr_data_i;
		end
		if (ld_ack_i) begin
			lq_addr[tail] <= req_addr;
			lq_rob_idx[tail] <= req_rob_idx;
			lq_dest_tag[tail] <= req_dest_tag;
			lq_br_mask[tail] <= req_mask_upd;
		end
	end

	// an acked miss always finds a free slot
	a_enq_not_full: assert property (@(posedge clk) disable iff (rst)
		ld_ack_i |-> !lq_full);

endmodule

`default_nettype wire

// File: logic/blocking_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module blocking_dcache import lsq_pkg::*; (
	input  wire               clk,
	input  wire               rst,
	input  wire               ld_en_i,
	input  wire [ADDR_W-1:0]  ld_addr_i,
	input  wire               st_en_i,
	input  wire [ADDR_W-1:0]  st_addr_i,
	input  wire [DATA_W-1:0]  st_data_i,
	output logic              hit_o,
	output logic [DATA_W-1:0] hit_data_o,
	output logic              ld_ack_o,
	output logic              mshr_stall_o,
	output logic              st_ack_o,
	output logic              mshr_vld_o,
	output logic [ADDR_W-1:0] mshr_addr_o,
	output logic [DATA_W-1:0] mshr_data_o
);

	logic [DATA_W-1:0]     mem [MEM_WORDS];
	logic [TAG_W-1:0]      line_tag [LINE_NUM];
	logic [LINE_NUM-1:0]   line_present;
	mshr_state_e           mshr_state;
	logic [MISS_CNT_W-1:0] mshr_cnt;
	logic [LINE_IDX_W-1:0] ld_line;
	logic [LINE_IDX_W-1:0] mshr_line;

	assign ld_line = ld_addr_i[OFS_W +: LINE_IDX_W];
	assign mshr_line = mshr_addr_o[OFS_W +: LINE_IDX_W];

	assign hit_o = ld_en_i && line_present[ld_line] &&
		(line_tag[ld_line] == ld_addr_i[ADDR_W-1 -: TAG_W]);
	assign hit_data_o = mem[ld_addr_i[OFS_W +: MEM_IDX_W]];
	assign ld_ack_o = ld_en_i && !hit_o && (mshr_state == MSHR_IDLE);
	assign mshr_stall_o = mshr_state != MSHR_IDLE;
	// write-through, no allocate
	assign st_ack_o = st_en_i && (mshr_state != MSHR_RESP);
	assign mshr_vld_o = mshr_state == MSHR_RESP;
	assign mshr_data_o = mem[mshr_addr_o[OFS_W +: MEM_IDX_W]];

	// *******************************************************************
	// single MSHR
	// *******************************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			mshr_state <= MSHR_IDLE;
			mshr_cnt <= '0;
			line_present <= '0;
		end else begin
			case (mshr_state)
				MSHR_IDLE: if (ld_ack_o) begin
					mshr_state <= MSHR_WAIT;
					mshr_cnt <= MISS_CNT_W'(MISS_LATENCY - 2);
				end
				MSHR_WAIT: if (mshr_cnt == '0)
					mshr_state <= MSHR_RESP;
				else
					mshr_cnt <= mshr_cnt - 1'b1;
				MSHR_RESP: begin
					mshr_state <= MSHR_IDLE;
					line_present[mshr_line] <= 1'b1;
				end
				default: mshr_state <= MSHR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ld_ack_o)
			mshr_addr_o <= ld_addr_i;
		if (mshr_state == MSHR_RESP)
			line_tag[mshr_line] <= mshr_addr_o[ADDR_W-1 -: TAG_W];
		if (st_ack_o)
			mem[st_addr_i[OFS_W +: MEM_IDX_W]] <= st_data_i;
	end

	// miss taken only when idle, answered after the fixed latency
	a_ack_idle: assert property (@(posedge clk) disable iff (rst)
		ld_ack_o |-> (mshr_state == MSHR_IDLE) ##MISS_LATENCY mshr_vld_o);

endmodule

`default_nettype wire

// File: logic/lsq_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsq_top import lsq_pkg::*; (
	input  wire                  clk,
	input  wire                  rst,
	input  wire                  dp_en_i,
	input  wire                  st_vld_i,
	input  wire [SQ_IDX_W-1:0]   sq_idx_i,
	input  wire [ADDR_W-1:0]     addr_i,
	input  wire [DATA_W-1:0]     st_data_i,
	input  wire                  st_retire_i,
	input  wire                  br_recovery_i,
	input  wire [SQ_IDX_W:0]     sq_tail_recovery_i,
	input  wire                  ld_vld_i,
	input  wire [ROB_IDX_W:0]    rob_idx_i,
	input  wire [PRF_IDX_W-1:0]  dest_tag_i,
	input  wire [BR_MASK_W-1:0]  br_mask_i,
	input  wire [SQ_IDX_W-1:0]   rs_ld_position_i,
	input  wire [SQ_IDX_W-1:0]   ex_ld_position_i,
	input  wire                  br_pred_correct_i,
	input  wire [BR_MASK_W-1:0]  br_tag_fix_i,
	input  wire                  cdb_busy_i,
	output logic [SQ_IDX_W:0]    sq_tail_o,
	output logic                 sq_full_o,
	output logic                 ld_iss_en_o,
	output logic                 ld_done_o,
	output logic [DATA_W-1:0]    ld_data_o,
	output logic [ROB_IDX_W:0]   ld_rob_idx_o,
	output logic [PRF_IDX_W-1:0] ld_dest_tag_o,
	output logic                 lq_com_rdy_o,
	output logic [DATA_W-1:0]    lq_data_o,
	output logic [ROB_IDX_W:0]   lq_rob_idx_o,
	output logic [PRF_IDX_W-1:0] lq_dest_tag_o,
	output logic [BR_MASK_W-1:0] lq_br_mask_o
);

	logic [SQ_IDX_W-1:0]               sq_head;
	logic [SQ_ENT_NUM-1:0][ADDR_W-1:0] st_addr_arr;
	logic [SQ_ENT_NUM-1:0][DATA_W-1:0] st_data_arr;
	logic [SQ_ENT_NUM-1:0]             st_addr_vld;
	logic                              st_en;
	logic [ADDR_W-1:0]                 st_addr;
	logic [DATA_W-1:0]                 st_data;
	logic                              st_ack;
	logic                              older_st_known;
	logic                              fwd_vld;
	logic [DATA_W-1:0]                 fwd_data;
	logic                              ld_en;
	logic [ADDR_W-1:0]                 ld_addr;
	logic                              hit;
	logic [DATA_W-1:0]                 hit_data;
	logic                              ld_ack;
	logic                              mshr_stall;
	logic                              mshr_vld;
	logic [ADDR_W-1:0]                 mshr_addr;
	logic [DATA_W-1:0]                 mshr_data;

	store_queue u_store_queue (
		.clk(clk), .rst(rst), .dp_en_i(dp_en_i), .st_vld_i(st_vld_i),
		.sq_idx_i(sq_idx_i), .addr_i(addr_i), .st_data_i(st_data_i),
		.st_retire_i(st_retire_i), .br_recovery_i(br_recovery_i),
		.sq_tail_recovery_i(sq_tail_recovery_i), .st_ack_i(st_ack),
		.sq_tail_o(sq_tail_o), .sq_head_o(sq_head), .sq_full_o(sq_full_o),
		.st_addr_arr_o(st_addr_arr), .st_data_arr_o(st_data_arr),
		.st_addr_vld_o(st_addr_vld), .st_en_o(st_en), .st_addr_o(st_addr),
		.st_data_o(st_data)
	);

	store_forward u_store_forward (
		.ld_vld_i(ld_vld_i), .addr_i(addr_i), .rs_ld_position_i(rs_ld_position_i),
		.ex_ld_position_i(ex_ld_position_i), .sq_head_i(sq_head), .sq_full_i(sq_full_o),
		.st_addr_arr_i(st_addr_arr), .st_data_arr_i(st_data_arr),
		.st_addr_vld_i(st_addr_vld), .older_st_known_o(older_st_known),
		.fwd_vld_o(fwd_vld), .fwd_data_o(fwd_data)
	);

	load_miss_queue u_load_miss_queue (
		.clk(clk), .rst(rst), .ld_vld_i(ld_vld_i), .addr_i(addr_i),
		.rob_idx_i(rob_idx_i), .dest_tag_i(dest_tag_i), .br_mask_i(br_mask_i),
		.fwd_vld_i(fwd_vld), .fwd_data_i(fwd_data), .older_st_known_i(older_st_known),
		.hit_i(hit), .hit_data_i(hit_data), .ld_ack_i(ld_ack),
		.mshr_stall_i(mshr_stall), .mshr_vld_i(mshr_vld), .mshr_addr_i(mshr_addr),
		.mshr_data_i(mshr_data), .br_recovery_i(br_recovery_i),
		.br_pred_correct_i(br_pred_correct_i), .br_tag_fix_i(br_tag_fix_i),
		.cdb_busy_i(cdb_busy_i), .ld_iss_en_o(ld_iss_en_o), .ld_en_o(ld_en),
		.ld_addr_o(ld_addr), .ld_done_o(ld_done_o), .ld_data_o(ld_data_o),
		.ld_rob_idx_o(ld_rob_idx_o), .ld_dest_tag_o(ld_dest_tag_o),
		.lq_com_rdy_o(lq_com_rdy_o), .lq_data_o(lq_data_o),
		.lq_rob_idx_o(lq_rob_idx_o), .lq_dest_tag_o(lq_dest_tag_o),
		.lq_br_mask_o(lq_br_mask_o)
	);

	blocking_dcache u_blocking_dcache (
		.clk(clk), .rst(rst), .ld_en_i(ld_en), .ld_addr_i(ld_addr),
		.st_en_i(st_en), .st_addr_i(st_addr), .st_data_i(st_data),
		.hit_o(hit), .hit_data_o(hit_data), .ld_ack_o(ld_ack),
		.mshr_stall_o(mshr_stall), .st_ack_o(st_ack), .mshr_vld_o(mshr_vld),
		.mshr_addr_o(mshr_addr), .mshr_data_o(mshr_data)
	);

endmodule

`default_nettype wire

// File: bench/lsq_tb_tasks.svh
`ifndef LSQ_TB_TASKS_SVH
`define LSQ_TB_TASKS_SVH

// *******************************************************************
// cycle stepping and compare
// *******************************************************************
// next cycle, strobes dropped
task automatic step();
	@(posedge clk);
	#DRV_DLY;
	dp_en_i = 1'b0;
	st_vld_i = 1'b0;
	st_retire_i = 1'b0;
	ld_vld_i = 1'b0;
	br_recovery_i = 1'b0;
	br_pred_correct_i = 1'b0;
endtask

task automatic check_val(input string name, input logic [DATA_W-1:0] exp,
	input logic [DATA_W-1:0] act);
	chk_cnt++;
	if (act !== exp) begin
		err_cnt++;
		$display("Fail %s expected %h actual %h", name, exp, act);
	end
endtask

// *******************************************************************
// store side
// *******************************************************************
task automatic dispatch_store(output logic [SQ_IDX_W-1:0] idx);
	step();
	dp_en_i = 1'b1;
	idx = tb_tail[SQ_IDX_W-1:0];
	tb_tail = tb_tail + 1'b1;
endtask

task automatic execute_store(input logic [SQ_IDX_W-1:0] idx, input logic [ADDR_W-1:0] addr,
	input logic [DATA_W-1:0] data);
	step();
	st_vld_i = 1'b1;
	sq_idx_i = idx;
	addr_i = addr;
	st_data_i = data;
endtask

// memory takes the value once the store retires
task automatic retire_store(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
	step();
	st_retire_i = 1'b1;
	ref_mem[addr[ADDR_W-1:OFS_W]] = data;
endtask

task automatic wait_drain(input string name);
	int n;
	n = 0;
	step();
	#1;
	while (u_lsq_top.st_en && n < TIMEOUT_CYC) begin
		step();
		#1;
		n++;
	end
	if (u_lsq_top.st_en)
		stop_on_timeout({name, ": store queue did not drain"});
endtask

task automatic store_word(input string name, input logic [ADDR_W-1:0] addr,
	input logic [DATA_W-1:0] data);
	logic [SQ_IDX_W-1:0] idx;
	dispatch_store(idx);
	execute_store(idx, addr, data);
	retire_store(addr, data);
	wait_drain(name);
endtask

// *******************************************************************
// load side
// *******************************************************************
function automatic logic cache_hit(input logic [ADDR_W-1:0] addr);
	logic [LINE_IDX_W-1:0] line;
	line = addr[OFS_W +: LINE_IDX_W];
	return ref_present[line] && (ref_tag[line] == addr[ADDR_W-1 -: TAG_W]);
endfunction

// dest tag kept apart from the rob tag
function automatic logic [PRF_IDX_W-1:0] dest_tag_of(input logic [ROB_IDX_W:0] rob);
	return ~PRF_IDX_W'(rob);
endfunction

// load sits at the current store tail
task automatic issue_load(input string name, input logic [ADDR_W-1:0] addr,
	input logic [BR_MASK_W-1:0] mask, input logic fwd, input logic [DATA_W-1:0] fwd_data);
	int                    n;
	logic                  exp_done;
	logic [DATA_W-1:0]     exp_data;
	logic [LINE_IDX_W-1:0] line;
	n = 0;
	line = addr[OFS_W +: LINE_IDX_W];
	rs_ld_position_i = tb_tail[SQ_IDX_W-1:0];
	ex_ld_position_i = tb_tail[SQ_IDX_W-1:0];
	#1;
	while (!ld_iss_en_o && n < TIMEOUT_CYC) begin
		step();
		#1;
		n++;
	end
	if (!ld_iss_en_o)
		stop_on_timeout({name, ": load issue permission never rose"});
	exp_done = fwd || cache_hit(addr);
	exp_data = fwd ? fwd_data : ref_mem[addr[ADDR_W-1:OFS_W]];
	step();
	ld_vld_i = 1'b1;
	addr_i = addr;
	rob_idx_i = rob_cnt;
	dest_tag_i = dest_tag_of(rob_cnt);
	br_mask_i = mask;
	#1;
	check_val({name, " done"}, exp_done, ld_done_o);
	if (exp_done) begin
		check_val({name, " data"}, exp_data, ld_data_o);
		check_val({name, " rob"}, rob_cnt, ld_rob_idx_o);
		check_val({name, " dest"}, dest_tag_of(rob_cnt), ld_dest_tag_o);
	end else begin
		exp_data_q.push_back(exp_data);
		exp_rob_q.push_back(rob_cnt);
		exp_mask_q.push_back(mask);
		// refill installs the line
		ref_present[line] = 1'b1;
		ref_tag[line] = addr[ADDR_W-1 -: TAG_W];
	end
	rob_cnt = rob_cnt + 1'b1;
endtask

task automatic count_to_completion(input string name, output int cycles);
	cycles = 0;
	#1;
	while (!lq_com_rdy_o && cycles < TIMEOUT_CYC) begin
		step();
		#1;
		cycles++;
	end
	if (!lq_com_rdy_o)
		stop_on_timeout({name, ": miss never completed"});
endtask

task automatic collect_completions(input string name);
	int                 n;
	logic [ROB_IDX_W:0] rob;
	#1;
	while (exp_data_q.size() > 0) begin
		n = 0;
		while (!lq_com_rdy_o && n < TIMEOUT_CYC) begin
			step();
			#1;
			n++;
		end
		if (!lq_com_rdy_o)
			stop_on_timeout({name, ": miss queue head never completed"});
		check_val({name, " data"}, exp_data_q.pop_front(), lq_data_o);
		rob = exp_rob_q.pop_front();
		check_val({name, " rob"}, rob, lq_rob_idx_o);
		check_val({name, " dest"}, dest_tag_of(rob), lq_dest_tag_o);
		check_val({name, " mask"}, exp_mask_q.pop_front(), lq_br_mask_o);
		step();
		#1;
	end
endtask

task automatic check_stalled_head(input string name, input int cycles);
	for (int k = 0; k < cycles; k++) begin
		step();
		#1;
		check_val({name, " valid"}, 1'b1, lq_com_rdy_o);
		check_val({name, " data"}, exp_data_q[0], lq_data_o);
		check_val({name, " rob"}, exp_rob_q[0], lq_rob_idx_o);
		check_val({name, " dest"}, dest_tag_of(exp_rob_q[0]), lq_dest_tag_o);
	end
endtask

task automatic quiet_cycles(input string name, input int cycles);
	for (int k = 0; k < cycles; k++) begin
		step();
		#1;
		check_val({name, " no completion"}, 1'b0, lq_com_rdy_o);
	end
endtask

// recovery reloads the store tail from tb_tail
task automatic resolve_branch(input logic mispredict, input logic [BR_MASK_W-1:0] fix);
	step();
	br_tag_fix_i = fix;
	br_recovery_i = mispredict;
	br_pred_correct_i = !mispredict;
	sq_tail_recovery_i = tb_tail;
endtask

`endif

// File: bench/lsq_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsq_tb import lsq_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int DRV_DLY = 5;
	localparam int TIMEOUT_CYC = 40;

	logic                 clk;
	logic                 rst;
	logic                 dp_en_i;
	logic                 st_vld_i;
	logic [SQ_IDX_W-1:0]  sq_idx_i;
	logic [ADDR_W-1:0]    addr_i;
	logic [DATA_W-1:0]    st_data_i;
	logic                 st_retire_i;
	logic                 br_recovery_i;
	logic [SQ_IDX_W:0]    sq_tail_recovery_i;
	logic                 ld_vld_i;
	logic [ROB_IDX_W:0]   rob_idx_i;
	logic [PRF_IDX_W-1:0] dest_tag_i;
	logic [BR_MASK_W-1:0] br_mask_i;
	logic [SQ_IDX_W-1:0]  rs_ld_position_i;
	logic [SQ_IDX_W-1:0]  ex_ld_position_i;
	logic                 br_pred_correct_i;
	logic [BR_MASK_W-1:0] br_tag_fix_i;
	logic                 cdb_busy_i;
	logic [SQ_IDX_W:0]    sq_tail_o;
	logic                 sq_full_o;
	logic                 ld_iss_en_o;
	logic                 ld_done_o;
	logic [DATA_W-1:0]    ld_data_o;
	logic [ROB_IDX_W:0]   ld_rob_idx_o;
	logic [PRF_IDX_W-1:0] ld_dest_tag_o;
	logic                 lq_com_rdy_o;
	logic [DATA_W-1:0]    lq_data_o;
	logic [ROB_IDX_W:0]   lq_rob_idx_o;
	logic [PRF_IDX_W-1:0] lq_dest_tag_o;
	logic [BR_MASK_W-1:0] lq_br_mask_o;

	// *******************************************************************
	// reference model
	// *******************************************************************
	logic [DATA_W-1:0]    ref_mem [MEM_WORDS];
	logic [TAG_W-1:0]     ref_tag [LINE_NUM];
	logic [LINE_NUM-1:0]  ref_present;
	// misses still owed by the head, oldest first
	logic [DATA_W-1:0]    exp_data_q[$];
	logic [ROB_IDX_W:0]   exp_rob_q[$];
	logic [BR_MASK_W-1:0] exp_mask_q[$];

	int                   err_cnt;
	int                   chk_cnt;
	integer               seed;
	logic [SQ_IDX_W:0]    tb_tail;
	logic [ROB_IDX_W:0]   rob_cnt;

	lsq_top u_lsq_top (.*);

	always #(CLK_PERIOD/2) clk = ~clk;

	task automatic stop_on_timeout(input string what);
		err_cnt++;
		$display("Timeout, %s", what);
		$display("checks %0d errors %0d", chk_cnt, err_cnt);
		$display("tests failed");
		$finish;
	endtask

	`include "lsq_tb_tasks.svh"

	function automatic logic [ADDR_W-1:0] rand_addr(input logic [LINE_IDX_W-1:0] line);
		logic [TAG_W-1:0] tag;
		logic [OFS_W-1:0] ofs;
		tag = TAG_W'($random(seed));
		ofs = OFS_W'($random(seed));
		return {tag, line, ofs};
	endfunction

	function automatic logic [DATA_W-1:0] rand_data();
		logic [DATA_W-1:0] d;
		d[63:32] = $random(seed);
		d[31:0] = $random(seed);
		return d;
	endfunction

	// *******************************************************************
	// directed tests
	// *******************************************************************
	task automatic store_then_load();
		logic [ADDR_W-1:0] a;
		int lat;
		a = rand_addr(4'd1);
		store_word("store_load", a, rand_data());
		issue_load("store_load miss", a, '0, 1'b0, '0);
		count_to_completion("store_load", lat);
		check_val("store_load latency", MISS_LATENCY, lat);
		collect_completions("store_load refill");
		issue_load("store_load hit", a, '0, 1'b0, '0);
	endtask

	task automatic store_forwarding();
		logic [ADDR_W-1:0]   a;
		logic [DATA_W-1:0]   d0;
		logic [DATA_W-1:0]   d1;
		logic [SQ_IDX_W-1:0] i0;
		logic [SQ_IDX_W-1:0] i1;
		a = rand_addr(4'd2);
		d0 = rand_data();
		d1 = rand_data();
		dispatch_store(i0);
		execute_store(i0, a, d0);
		// other byte offset, same word
		issue_load("forward one", a ^ ADDR_W'(7), '0, 1'b1, d0);
		dispatch_store(i1);
		execute_store(i1, a, d1);
		issue_load("forward youngest", a, '0, 1'b1, d1);
		retire_store(a, d0);
		retire_store(a, d1);
		wait_drain("forward");
	endtask

	task automatic issue_gating();
		logic [ADDR_W-1:0]   a;
		logic [DATA_W-1:0]   d;
		logic [SQ_IDX_W-1:0] idx;
		a = rand_addr(4'd3);
		d = rand_data();
		dispatch_store(idx);
		rs_ld_position_i = tb_tail[SQ_IDX_W-1:0];
		#1;
		check_val("gating unknown", 1'b0, ld_iss_en_o);
		execute_store(idx, a, d);
		#1;
		check_val("gating execute", 1'b0, ld_iss_en_o);
		step();
		#1;
		check_val("gating known", 1'b1, ld_iss_en_o);
		retire_store(a, d);
		wait_drain("gating");
	endtask

	task automatic miss_backpressure();
		logic [ADDR_W-1:0] a [3];
		for (int k = 0; k < 3; k++) begin
			a[k] = rand_addr(LINE_IDX_W'(4 + k));
			store_word("backpressure", a[k], rand_data());
		end
		step();
		cdb_busy_i = 1'b1;
		for (int k = 0; k < 3; k++)
			issue_load("backpressure miss", a[k], '0, 1'b0, '0);
		check_stalled_head("backpressure hold", MISS_LATENCY + 2);
		step();
		cdb_busy_i = 1'b0;
		collect_completions("backpressure order");
	endtask

	task automatic branch_squash();
		logic [ADDR_W-1:0] a0;
		logic [ADDR_W-1:0] a1;
		a0 = rand_addr(4'd7);
		a1 = rand_addr(4'd8);
		store_word("squash", a0, rand_data());
		store_word("squash", a1, rand_data());
		issue_load("squash victim", a0, 4'b0001, 1'b0, '0);
		void'(exp_data_q.pop_back());
		void'(exp_rob_q.pop_back());
		void'(exp_mask_q.pop_back());
		resolve_branch(1'b1, 4'b0001);
		quiet_cycles("squash", MISS_LATENCY + 1);
		issue_load("squash survivor", a1, 4'b0010, 1'b0, '0);
		resolve_branch(1'b0, 4'b0010);
		exp_mask_q[0] = exp_mask_q[0] & ~4'b0010;
		collect_completions("squash survivor");
	endtask

	task automatic full_and_recovery();
		logic [SQ_IDX_W-1:0] idx;
		logic [SQ_IDX_W:0]   rec_tail;
		rec_tail = tb_tail;
		for (int k = 0; k < SQ_ENT_NUM; k++) begin
			if (k == 3)
				rec_tail = tb_tail;
			dispatch_store(idx);
		end
		step();
		#1;
		check_val("full flag", 1'b1, sq_full_o);
		check_val("full tail", tb_tail, sq_tail_o);
		tb_tail = rec_tail;
		resolve_branch(1'b1, '0);
		step();
		#1;
		check_val("recovery tail", rec_tail, sq_tail_o);
		check_val("recovery full", 1'b0, sq_full_o);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		dp_en_i = 1'b0;
		st_vld_i = 1'b0;
		sq_idx_i = '0;
		addr_i = '0;
		st_data_i = '0;
		st_retire_i = 1'b0;
		br_recovery_i = 1'b0;
		sq_tail_recovery_i = '0;
		ld_vld_i = 1'b0;
		rob_idx_i = '0;
		dest_tag_i = '0;
		br_mask_i = '0;
		rs_ld_position_i = '0;
		ex_ld_position_i = '0;
		br_pred_correct_i = 1'b0;
		br_tag_fix_i = '0;
		cdb_busy_i = 1'b0;
		ref_present = '0;
		err_cnt = 0;
		chk_cnt = 0;
		seed = 32'h5c6c;
		tb_tail = '0;
		rob_cnt = '0;
		repeat (2) @(posedge clk);
		#DRV_DLY;
		rst = 1'b0;

		store_then_load();
		store_forwarding();
		issue_gating();
		miss_backpressure();
		branch_squash();
		full_and_recovery();

		step();
		$display("checks %0d errors %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+bench
logic/lsq_pkg.sv
logic/store_queue.sv
logic/store_forward.sv
logic/load_miss_queue.sv
logic/blocking_dcache.sv
logic/lsq_top.sv
bench/lsq_tb.sv
